// File: src/mips_ex_macros.svh
`ifndef MIPS_EX_MACROS_SVH
`define MIPS_EX_MACROS_SVH

// Datapath widths
`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_IMM_W       16
`define MIPS_SHAMT_W     5
`define MIPS_LUI_SHAMT   5'd16

// Primary opcodes
`define MIPS_OP_SPECIAL  6'h00
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_ADDIU    6'h09
`define MIPS_OP_SLTI     6'h0a
`define MIPS_OP_ANDI     6'h0c
`define MIPS_OP_ORI      6'h0d
`define MIPS_OP_XORI     6'h0e
`define MIPS_OP_LUI      6'h0f

// SPECIAL funct codes
`define MIPS_FN_SLL      6'h00
`define MIPS_FN_SRL      6'h02
`define MIPS_FN_SRA      6'h03
`define MIPS_FN_SLLV     6'h04
`define MIPS_FN_SRLV     6'h06
`define MIPS_FN_SRAV     6'h07
`define MIPS_FN_MOVZ     6'h0a
`define MIPS_FN_MOVN     6'h0b
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_ADDU     6'h21
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_SUBU     6'h23
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_XOR      6'h26
`define MIPS_FN_NOR      6'h27
`define MIPS_FN_SLT      6'h2a
`define MIPS_FN_SLTU     6'h2b

`endif

// File: src/mips_ex_pkg.sv
`include "mips_ex_macros.svh"

package mips_ex_pkg;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    typedef struct packed {
        logic [5:0]                  opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [`MIPS_SHAMT_W-1:0]    shamt;
        logic [5:0]                  funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]                  opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_IMM_W-1:0]      imm;
    } i_view_t;

    // Same 32 bits seen as R-type or I-type layout
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

    //////////////////////////////
    // Operation codes
    //////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS
    } alu_op_e;

    // Encoding follows funct[1:0] of the shift instructions
    typedef enum logic [1:0] {
        SH_SLL = 2'b00,
        SH_SRL = 2'b10,
        SH_SRA = 2'b11
    } shift_op_e;

    typedef enum logic {
        RES_ALU,
        RES_SHIFT
    } res_sel_e;

    // Five rules need three bits
    typedef enum logic [2:0] {
        WR_ALWAYS,
        WR_NO_OVF,
        WR_RT_ZERO,
        WR_RT_NONZERO,
        WR_NEVER
    } wr_rule_e;

endpackage

// File: src/ex_op_if.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

// Decoded operation from the issue stage to the ALU and shift paths
interface ex_op_if;
    logic                        valid;
    mips_ex_pkg::alu_op_e        alu_op;
    mips_ex_pkg::shift_op_e      shift_op;
    logic                        shamt_var;
    logic [`MIPS_WORD_W-1:0]     a;
    logic [`MIPS_WORD_W-1:0]     b;
    logic [`MIPS_SHAMT_W-1:0]    shamt;
    logic [`MIPS_REG_ADDR_W-1:0] dest;
    mips_ex_pkg::res_sel_e       res_sel;
    mips_ex_pkg::wr_rule_e       wr_rule;

    modport issue (
        output valid, alu_op, shift_op, shamt_var, a, b, shamt, dest, res_sel, wr_rule
    );
    modport path (
        input valid, alu_op, shift_op, shamt_var, a, b, shamt, dest, res_sel, wr_rule
    );
endinterface

// ALU result plus the control fields that ride along with it
interface alu_res_if;
    logic                        valid;
    logic [`MIPS_WORD_W-1:0]     result;
    logic                        overflow;
    logic                        rt_zero;
    logic [`MIPS_REG_ADDR_W-1:0] dest;
    mips_ex_pkg::res_sel_e       res_sel;
    mips_ex_pkg::wr_rule_e       wr_rule;

    modport alu (output valid, result, overflow, rt_zero, dest, res_sel, wr_rule);
    modport merge (input valid, result, overflow, rt_zero, dest, res_sel, wr_rule);
endinterface

// File: src/ex_issue.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

module ex_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  mips_ex_pkg::instr_u     instr,
    input  logic [`MIPS_WORD_W-1:0] rs_data,
    input  logic [`MIPS_WORD_W-1:0] rt_data,
    input  logic                    advance,
    ex_op_if.issue                  op
);

    mips_ex_pkg::alu_op_e        alu_op_d;
    mips_ex_pkg::shift_op_e      shift_op_d;
    logic                        shamt_var_d;
    logic [`MIPS_SHAMT_W-1:0]    shamt_d;
    mips_ex_pkg::res_sel_e       res_sel_d;
    mips_ex_pkg::wr_rule_e       wr_rule_d;
    logic                        special;
    logic                        imm_signed;
    logic [`MIPS_WORD_W-1:0]     imm_ext;
    logic [`MIPS_WORD_W-1:0]     b_d;
    logic [`MIPS_REG_ADDR_W-1:0] dest_d;

    assign in_ready = advance;

    //////////////////////////////
    // Operand and destination
    //////////////////////////////

    assign special    = (instr.i.opcode == `MIPS_OP_SPECIAL);
    assign imm_signed = (instr.i.opcode == `MIPS_OP_ADDI) ||
                        (instr.i.opcode == `MIPS_OP_ADDIU) ||
                        (instr.i.opcode == `MIPS_OP_SLTI);
    assign imm_ext = imm_signed
        ? {{(`MIPS_WORD_W-`MIPS_IMM_W){instr.i.imm[`MIPS_IMM_W-1]}}, instr.i.imm}
        : {{(`MIPS_WORD_W-`MIPS_IMM_W){1'b0}}, instr.i.imm};

    // rd for R-type, rt for I-type
    assign dest_d = special ? instr.r.rd : instr.i.rt;
    assign b_d    = special ? rt_data : imm_ext;

    //////////////////////////////
    // Opcode and funct decode
    //////////////////////////////

    always_comb begin
        alu_op_d    = mips_ex_pkg::ALU_PASS;
        // Shift kind and variable amount come straight from funct bits
        shift_op_d  = instr.r.funct[1] ?
                      (instr.r.funct[0] ? mips_ex_pkg::SH_SRA : mips_ex_pkg::SH_SRL) :
                      mips_ex_pkg::SH_SLL;
        shamt_var_d = instr.r.funct[2];
        shamt_d     = instr.r.shamt;
        res_sel_d   = mips_ex_pkg::RES_ALU;
        wr_rule_d   = mips_ex_pkg::WR_ALWAYS;
        if (special) begin
            case (instr.r.funct)
                `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA,
                `MIPS_FN_SLLV, `MIPS_FN_SRLV, `MIPS_FN_SRAV:
                    res_sel_d = mips_ex_pkg::RES_SHIFT;
                `MIPS_FN_MOVZ: wr_rule_d = mips_ex_pkg::WR_RT_ZERO;
                `MIPS_FN_MOVN: wr_rule_d = mips_ex_pkg::WR_RT_NONZERO;
                `MIPS_FN_ADD: begin
                    alu_op_d  = mips_ex_pkg::ALU_ADD;
                    wr_rule_d = mips_ex_pkg::WR_NO_OVF;
                end
                `MIPS_FN_SUB: begin
                    alu_op_d  = mips_ex_pkg::ALU_SUB;
                    wr_rule_d = mips_ex_pkg::WR_NO_OVF;
                end
                `MIPS_FN_ADDU: alu_op_d = mips_ex_pkg::ALU_ADD;
                `MIPS_FN_SUBU: alu_op_d = mips_ex_pkg::ALU_SUB;
                `MIPS_FN_AND:  alu_op_d = mips_ex_pkg::ALU_AND;
                `MIPS_FN_OR:   alu_op_d = mips_ex_pkg::ALU_OR;
                `MIPS_FN_XOR:  alu_op_d = mips_ex_pkg::ALU_XOR;
                `MIPS_FN_NOR:  alu_op_d = mips_ex_pkg::ALU_NOR;
                `MIPS_FN_SLT:  alu_op_d = mips_ex_pkg::ALU_SLT;
                `MIPS_FN_SLTU: alu_op_d = mips_ex_pkg::ALU_SLTU;
                default:       wr_rule_d = mips_ex_pkg::WR_NEVER;
            endcase
        end else begin
            case (instr.i.opcode)
                `MIPS_OP_ADDI: begin
                    alu_op_d  = mips_ex_pkg::ALU_ADD;
                    wr_rule_d = mips_ex_pkg::WR_NO_OVF;
                end
                `MIPS_OP_ADDIU: alu_op_d = mips_ex_pkg::ALU_ADD;
                `MIPS_OP_SLTI:  alu_op_d = mips_ex_pkg::ALU_SLT;
                `MIPS_OP_ANDI:  alu_op_d = mips_ex_pkg::ALU_AND;
                `MIPS_OP_ORI:   alu_op_d = mips_ex_pkg::ALU_OR;
                `MIPS_OP_XORI:  alu_op_d = mips_ex_pkg::ALU_XOR;
                // LUI is the zero-extended immediate shifted left by 16
                `MIPS_OP_LUI: begin
                    res_sel_d   = mips_ex_pkg::RES_SHIFT;
                    shift_op_d  = mips_ex_pkg::SH_SLL;
                    shamt_var_d = 1'b0;
                    shamt_d     = `MIPS_LUI_SHAMT;
                end
                default: wr_rule_d = mips_ex_pkg::WR_NEVER;
            endcase
        end
    end

    //////////////////////////////
    // Issue register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else if (advance) begin
            op.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op.alu_op    <= alu_op_d;
            op.shift_op  <= shift_op_d;
            op.shamt_var <= shamt_var_d;
            op.a         <= rs_data;
            op.b         <= b_d;
            op.shamt     <= shamt_d;
            op.dest      <= dest_d;
            op.res_sel   <= res_sel_d;
            op.wr_rule   <= wr_rule_d;
        end
    end

endmodule

// File: src/alu_path.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

module alu_path (
    input  logic  clk,
    input  logic  rst,
    input  logic  advance,
    ex_op_if.path op,
    alu_res_if.alu res
);

    logic [`MIPS_WORD_W-1:0] sum;
    logic [`MIPS_WORD_W-1:0] diff;
    logic [`MIPS_WORD_W-1:0] alu_d;
    logic                    a_msb;
    logic                    b_msb;
    logic                    ovf_d;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign sum   = op.a + op.b;
    assign diff  = op.a - op.b;
    assign a_msb = op.a[`MIPS_WORD_W-1];
    assign b_msb = op.b[`MIPS_WORD_W-1];

    assign lt_signed   = $signed(op.a) < $signed(op.b);
    assign lt_unsigned = op.a < op.b;

    always_comb begin
        case (op.alu_op)
            mips_ex_pkg::ALU_ADD:  alu_d = sum;
            mips_ex_pkg::ALU_SUB:  alu_d = diff;
            mips_ex_pkg::ALU_AND:  alu_d = op.a & op.b;
            mips_ex_pkg::ALU_OR:   alu_d = op.a | op.b;
            mips_ex_pkg::ALU_XOR:  alu_d = op.a ^ op.b;
            mips_ex_pkg::ALU_NOR:  alu_d = ~(op.a | op.b);
            mips_ex_pkg::ALU_SLT:  alu_d = {{(`MIPS_WORD_W-1){1'b0}}, lt_signed};
            mips_ex_pkg::ALU_SLTU: alu_d = {{(`MIPS_WORD_W-1){1'b0}}, lt_unsigned};
            // Moves hand rs through unchanged
            default:               alu_d = op.a;
        endcase
    end

    // Signed overflow when operands of like sign give a result of the other sign
    always_comb begin
        case (op.alu_op)
            mips_ex_pkg::ALU_ADD: ovf_d = (a_msb == b_msb) && (sum[`MIPS_WORD_W-1] != a_msb);
            mips_ex_pkg::ALU_SUB: ovf_d = (a_msb != b_msb) && (diff[`MIPS_WORD_W-1] != a_msb);
            default:              ovf_d = 1'b0;
        endcase
    end

    //////////////////////////////
    // Result register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else if (advance) begin
            res.valid <= op.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            res.result   <= alu_d;
            res.overflow <= ovf_d;
            res.rt_zero  <= (op.b == '0);
            res.dest     <= op.dest;
            res.res_sel  <= op.res_sel;
            res.wr_rule  <= op.wr_rule;
        end
    end

endmodule

// File: src/shift_path.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

module shift_path (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    ex_op_if.path                   op,
    output logic [`MIPS_WORD_W-1:0] shift_result
);

    logic [`MIPS_SHAMT_W-1:0] amount;
    logic [`MIPS_WORD_W-1:0]  shifted;

    // Variable forms take the low five bits of rs
    assign amount = op.shamt_var ? op.a[`MIPS_SHAMT_W-1:0] : op.shamt;

    //////////////////////////////
    // Barrel shifter
    //////////////////////////////

    always_comb begin
        case (op.shift_op)
            mips_ex_pkg::SH_SRL: shifted = op.b >> amount;
            // Sign bit fills from the left
            mips_ex_pkg::SH_SRA: shifted = $signed(op.b) >>> amount;
            default:             shifted = op.b << amount;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_result <= '0;
        end else if (advance) begin
            shift_result <= shifted;
        end
    end

endmodule

// File: src/ex_merge.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

module ex_merge (
    input  logic                        clk,
    input  logic                        rst,
    alu_res_if.merge                    res,
    input  logic [`MIPS_WORD_W-1:0]     shift_result,
    input  logic                        out_ready,
    output logic                        out_valid,
    output logic [`MIPS_WORD_W-1:0]     result,
    output logic [`MIPS_REG_ADDR_W-1:0] dest,
    output logic                        reg_write,
    output logic                        advance
);

    logic [`MIPS_WORD_W-1:0] result_d;
    logic                    write_d;

    // Whole pipe moves when the output slot is free or being drained
    assign advance = !out_valid || out_ready;

    assign result_d = (res.res_sel == mips_ex_pkg::RES_SHIFT) ? shift_result : res.result;

    //////////////////////////////
    // Register write rules
    //////////////////////////////

    always_comb begin
        case (res.wr_rule)
            mips_ex_pkg::WR_ALWAYS:     write_d = 1'b1;
            mips_ex_pkg::WR_NO_OVF:     write_d = !res.overflow;
            mips_ex_pkg::WR_RT_ZERO:    write_d = res.rt_zero;
            mips_ex_pkg::WR_RT_NONZERO: write_d = !res.rt_zero;
            default:                    write_d = 1'b0;
        endcase
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= res.valid;
        end
    end

    // Held steady while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            result    <= result_d;
            dest      <= res.dest;
            reg_write <= write_d;
        end
    end

endmodule

// File: src/mips_ex_top.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

module mips_ex_top (
    input  logic                        clk,
    input  logic                        rst,
    // Instruction in
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`MIPS_WORD_W-1:0]     instr,
    input  logic [`MIPS_WORD_W-1:0]     rs_data,
    input  logic [`MIPS_WORD_W-1:0]     rt_data,
    // Result out
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`MIPS_WORD_W-1:0]     result,
    output logic [`MIPS_REG_ADDR_W-1:0] dest,
    output logic                        reg_write
);

    logic                    advance;
    logic [`MIPS_WORD_W-1:0] shift_result;

    ex_op_if   u_op_if ();
    alu_res_if u_res_if ();

    //////////////////////////////
    // Stages
    //////////////////////////////

    ex_issue u_ex_issue (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .in_valid ( in_valid ),
        .in_ready ( in_ready ),
        .instr    ( instr    ),
        .rs_data  ( rs_data  ),
        .rt_data  ( rt_data  ),
        .advance  ( advance  ),
        .op       ( u_op_if  )
    );

    alu_path u_alu_path (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .advance ( advance  ),
        .op      ( u_op_if  ),
        .res     ( u_res_if )
    );

    shift_path u_shift_path (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .advance      ( advance      ),
        .op           ( u_op_if      ),
        .shift_result ( shift_result )
    );

    ex_merge u_ex_merge (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .res          ( u_res_if     ),
        .shift_result ( shift_result ),
        .out_ready    ( out_ready    ),
        .out_valid    ( out_valid    ),
        .result       ( result       ),
        .dest         ( dest         ),
        .reg_write    ( reg_write    ),
        .advance      ( advance      )
    );

endmodule

// File: tests/tb_mips_ex.sv
`timescale 1ns/100ps
`include "mips_ex_macros.svh"

module tb_mips_ex;

    localparam int MAX_VEC = 64;
    localparam int FIELDS  = 6;
    localparam int LATENCY = 3;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        in_valid;
    logic                        in_ready;
    logic [`MIPS_WORD_W-1:0]     instr;
    logic [`MIPS_WORD_W-1:0]     rs_data;
    logic [`MIPS_WORD_W-1:0]     rt_data;
    logic                        out_valid;
    logic                        out_ready;
    logic [`MIPS_WORD_W-1:0]     result;
    logic [`MIPS_REG_ADDR_W-1:0] dest;
    logic                        reg_write;

    // Six words per vector as laid out in tests/ex_stim.hex
    logic [31:0] stim_mem [0:MAX_VEC*FIELDS-1];
    int          num_vec = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    logic [31:0] lfsr_state = 32'hc9d8_eec5;

    // Scoreboard of vector index and handshake cycle per item in flight
    int          pend_idx[$];
    int          pend_cycle[$];

    mips_ex_top u_mips_ex_top (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .in_valid  ( in_valid  ),
        .in_ready  ( in_ready  ),
        .instr     ( instr     ),
        .rs_data   ( rs_data   ),
        .rt_data   ( rt_data   ),
        .out_valid ( out_valid ),
        .out_ready ( out_ready ),
        .result    ( result    ),
        .dest      ( dest      ),
        .reg_write ( reg_write )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // True about one time in four
    function automatic logic one_in_four();
        logic b0;
        logic b1;
        b0 = rand_bit();
        b1 = rand_bit();
        return b0 & b1;
    endfunction

    // Marks slots the data file did not fill
    function automatic logic [31:0] fill_word(input int addr);
        return 32'hdead_0000 ^ addr;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_output(input int idx);
        logic [31:0] flags;
        string       tag;
        flags = stim_mem[idx*FIELDS+5];
        tag   = $sformatf("vec %0d", idx);
        // Bit 4 of the flags leaves the result unchecked
        if (!flags[4]) begin
            check_value({tag, " result"}, stim_mem[idx*FIELDS+3], result);
        end
        check_value({tag, " dest"}, stim_mem[idx*FIELDS+4], {27'd0, dest});
        check_value({tag, " reg_write"}, {31'd0, flags[0]}, {31'd0, reg_write});
    endtask

    //////////////////////////////
    // One pass over all vectors
    //////////////////////////////

    task automatic run_pass(input logic random_mode);
        int          next_vec;
        int          outputs;
        int          idx;
        int          in_cyc;
        logic        take_in;
        logic        take_out;
        logic        gap;
        logic        held;
        logic [31:0] held_result;
        logic [31:0] held_dest;
        logic        held_write;
        next_vec = 0;
        outputs  = 0;
        held     = 1'b0;
        while (next_vec < num_vec || in_valid || pend_idx.size() > 0) begin
            @(posedge clk);
            take_in  = in_valid && in_ready;
            take_out = out_valid && out_ready;

            // Without stalls every offered input is taken at once
            if (!random_mode && in_valid) begin
                check_value("in_ready without stalls", 32'd1, {31'd0, in_ready});
            end

            // Stalled output must keep its data
            if (held && out_valid) begin
                check_value("stall hold result", held_result, result);
                check_value("stall hold dest", held_dest, {27'd0, dest});
                check_value("stall hold reg_write", {31'd0, held_write}, {31'd0, reg_write});
            end
            held        = out_valid && !out_ready;
            held_result = result;
            held_dest   = {27'd0, dest};
            held_write  = reg_write;

            if (take_in) begin
                pend_idx.push_back(next_vec);
                pend_cycle.push_back(cycle);
                next_vec++;
            end

            if (take_out) begin
                if (pend_idx.size() == 0) begin
                    errors++;
                    $display("Output at cycle %0d arrived with no input pending", cycle);
                end else begin
                    idx    = pend_idx.pop_front();
                    in_cyc = pend_cycle.pop_front();
                    compare_output(idx);
                    if (!random_mode) begin
                        check_value($sformatf("vec %0d latency", idx), LATENCY, cycle - in_cyc);
                    end
                    outputs++;
                end
            end

            // Next input is held until taken
            if (!in_valid || take_in) begin
                gap = 1'b0;
                if (random_mode) begin
                    gap = one_in_four();
                end
                if (next_vec < num_vec && !gap) begin
                    in_valid <= 1'b1;
                    instr    <= stim_mem[next_vec*FIELDS];
                    rs_data  <= stim_mem[next_vec*FIELDS+1];
                    rt_data  <= stim_mem[next_vec*FIELDS+2];
                end else begin
                    in_valid <= 1'b0;
                end
            end

            if (random_mode) begin
                out_ready <= !one_in_four();
            end else begin
                out_ready <= 1'b1;
            end
        end
        check_value("output count", num_vec, outputs);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int count;
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        instr     <= '0;
        rs_data   <= '0;
        rt_data   <= '0;
        out_ready <= 1'b0;

        for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
            stim_mem[i] = fill_word(i);
        end
        $readmemh("tests/ex_stim.hex", stim_mem);
        count = 0;
        while (count < MAX_VEC && stim_mem[count*FIELDS] != fill_word(count*FIELDS)) begin
            count++;
        end
        num_vec = count;
        if (num_vec == 0) begin
            errors++;
            $display("No vectors were found in tests/ex_stim.hex");
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("out_valid after reset", 32'd0, {31'd0, out_valid});
        check_value("in_ready after reset", 32'd1, {31'd0, in_ready});

        if (num_vec > 0) begin
            // Back-to-back with no stalls, then random gaps and stalls
            run_pass(1'b0);
            run_pass(1'b1);
        end

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (num_vec > 0);
        repeat (num_vec * 20 + 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", num_vec * 20 + 200);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tests/ex_stim.hex
// instr    rs_data  rt_data  result   dest flags
// Flags bit 0 is the expected reg_write, bit 4 leaves the result unchecked
00221820 00000005 00000007 0000000c 03 01 // ADD
00222020 7fffffff 00000001 80000000 04 00 // ADD overflow
00222821 7fffffff 00000001 80000000 05 01 // ADDU same operands
00223022 80000000 00000001 7fffffff 06 00 // SUB overflow
00223823 00000003 00000005 fffffffe 07 01 // SUBU
00224024 f0f0f0f0 ff00ff00 f000f000 08 01 // AND
00224825 f0f0f0f0 0f000f00 fff0fff0 09 01 // OR
00225026 ffff0000 0ff00ff0 f00f0ff0 0a 01 // XOR
00225827 0000ffff 00ff0000 ff000000 0b 01 // NOR
0022602a ffffffff 00000001 00000001 0c 01 // SLT
0022682b ffffffff 00000001 00000000 0d 01 // SLTU
202effff 00000010 12345678 0000000f 0e 01 // ADDI sign extended
202f0001 7fffffff 12345678 80000000 0f 00 // ADDI overflow
24308000 00000000 12345678 ffff8000 10 01 // ADDIU
2831ffff fffffffe 12345678 00000001 11 01 // SLTI
3032ffff 12345678 00000000 00005678 12 01 // ANDI zero extended
34338001 00010000 00000000 00018001 13 01 // ORI
3834ffff ffffffff 00000000 ffff0000 14 01 // XORI
3c151234 deadbeef 00000000 12340000 15 01 // LUI
0002b100 0000001f 8000000f 000000f0 16 01 // SLL
0002ba02 0000001f 80000000 00800000 17 01 // SRL
0002c203 0000001f 80000000 ff800000 18 01 // SRA
0022c804 00000024 00000001 00000010 19 01 // SLLV
0022d006 ffffffe8 f0000000 00f00000 1a 01 // SRLV
0022d807 0000003f 80000000 ffffffff 1b 01 // SRAV
0022e00a cafef00d 00000000 cafef00d 1c 01 // MOVZ taken
0022e80a cafef00d 00000001 cafef00d 1d 00 // MOVZ not taken
0022f00b 13579bdf 00000002 13579bdf 1e 01 // MOVN taken
0022f80b 13579bdf 00000000 13579bdf 1f 00 // MOVN not taken
fc230005 11111111 22222222 00000000 03 10 // Unknown opcode
00221801 11111111 22222222 00000000 03 10 // Unknown funct

// File: files.f
+incdir+src
src/mips_ex_pkg.sv
src/ex_op_if.sv
src/ex_issue.sv
src/alu_path.sv
src/shift_path.sv
src/ex_merge.sv
src/mips_ex_top.sv
tests/tb_mips_ex.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_mips_ex -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
